// File: common/mem_ctrl_pkg.sv
// controller-side definitions: state encoding, beat counter and decoder flags
// imported by the state machine, the state decoder and the command mux

package mem_ctrl_pkg;

  // controller states, IO_SEL doubles as idle and arbitration
  typedef enum logic [2:0] {
    IO_SEL         = 3'b000,
    IO_ACK_WAIT    = 3'b001,
    DC_MEM_RD      = 3'b010,
    DC_MISS_ACK    = 3'b011,
    IC_MEM_RD      = 3'b100,
    IC_MISS_ACK    = 3'b101,
    DC_MEM_WR      = 3'b110,
    DC_CLEAR_EVICT = 3'b111
  } mem_st_t;

  localparam int NUM_ST    = 1 << $bits(mem_st_t);
  localparam int CNT_W     = 3;
  localparam int BURST_LEN = 1 << CNT_W;

  // one-bit equality flags, state flags indexed by the state encoding
  typedef struct packed {
    logic [NUM_ST-1:0]    curr_eq;
    logic [NUM_ST-1:0]    next_eq;
    logic [NUM_ST-1:0]    curr_ne;
    logic [BURST_LEN-1:0] cnt_eq;
  } st_flags_t;

  // kind of memory command the mux builds on an issue strobe
  typedef enum logic [1:0] {
    CMD_EVICT_WR,
    CMD_DC_RD,
    CMD_IC_RD,
    CMD_IO
  } cmd_kind_t;

  // latch captures the request fields in the accept cycle
  typedef struct packed {
    logic      latch;
    cmd_kind_t kind;
  } cmd_sel_t;

endpackage

// File: common/mem_bus_pkg.sv
// bus-side definitions: word and address sizes, request, command and fill types
// shared by the datapath blocks, the top level and the testbench

package mem_bus_pkg;

  localparam int DATA_W = 32;
  localparam int ADDR_W = 16;
  localparam int LINE_W = 13;
  // word offset inside a line
  localparam int BEAT_W = ADDR_W - LINE_W;

  typedef logic [LINE_W-1:0] line_addr_t;

  typedef struct packed {
    line_addr_t        line;
    logic [BEAT_W-1:0] beat;
  } line_view_t;

  // one memory word address, seen as line plus beat or as a flat word
  typedef union packed {
    line_view_t        ln;
    logic [ADDR_W-1:0] word;
  } mem_addr_u;

  typedef logic [(1 << BEAT_W)-1:0][DATA_W-1:0] line_t;

  typedef struct packed {
    line_addr_t fill_addr;
    logic       evict;
    line_addr_t evict_addr;
    line_t      evict_line;
  } dc_req_t;

  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } io_req_t;

  // burst set means an eight-beat read of the addressed line
  typedef struct packed {
    logic              write;
    logic              burst;
    mem_addr_u         addr;
    logic [DATA_W-1:0] wdata;
  } mem_cmd_t;

  typedef struct packed {
    line_addr_t line_addr;
    line_t      data;
  } fill_t;

endpackage

// File: mem_ctrl/st_eq_checker.sv
// state and beat count decoder for the memory controller FSM
// purely combinational, all next-state and output logic is built on its flags

module st_eq_checker (
  input  mem_ctrl_pkg::mem_st_t            curr_st,
  input  mem_ctrl_pkg::mem_st_t            next_st,
  input  logic [mem_ctrl_pkg::CNT_W-1:0]   count,
  output mem_ctrl_pkg::st_flags_t          flags
);

  import mem_ctrl_pkg::*;

  // one compare per encoding, flag index equals the state value
  always_comb begin
    for (int i = 0; i < NUM_ST; i++) begin
      flags.curr_eq[i] = (curr_st == mem_st_t'(i));
      flags.next_eq[i] = (next_st == mem_st_t'(i));
    end
  end

  // inverted copies feed the active-low enables
  assign flags.curr_ne = ~flags.curr_eq;

  always_comb begin
    for (int i = 0; i < BURST_LEN; i++) begin
      flags.cnt_eq[i] = (count == CNT_W'(i));
    end
  end

endmodule

// File: mem_ctrl/mem_ctrl_fsm.sv
// controller FSM: fixed-priority arbitration, beat counting and handshakes
// drives the line buffer and command mux controls, flags come from st_eq_checker

module mem_ctrl_fsm (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            dc_req_valid,
  input  logic                            ic_req_valid,
  input  logic                            io_req_valid,
  input  logic                            dc_evict,
  input  logic                            io_write,
  output logic                            dc_req_ready,
  output logic                            ic_req_ready,
  output logic                            io_req_ready,
  input  logic                            mem_cmd_ready,
  input  logic                            mem_rd_valid,
  output logic                            cmd_issue,
  output mem_ctrl_pkg::cmd_sel_t          cmd_sel,
  output logic                            beat_capture,
  output logic                            evict_load,
  output logic                            dc_fill_valid,
  output logic                            ic_fill_valid,
  output logic                            io_rsp_valid,
  output logic [mem_ctrl_pkg::CNT_W-1:0]  count
);

  import mem_ctrl_pkg::*;

  mem_st_t   curr_st;
  mem_st_t   next_st;
  st_flags_t flags;
  // one-hot accept: bit 0 dc, bit 1 ic, bit 2 io
  logic [2:0] grant;
  logic       cmd_pend;
  logic       io_sent;
  logic       io_wr_q;
  logic       accept;
  logic       cmd_acc;
  logic       cnt_en;
  logic       last_beat;
  logic       miss_ack;

  st_eq_checker i_st_eq (
    .curr_st (curr_st),
    .next_st (next_st),
    .count   (count),
    .flags   (flags)
  );

  assign dc_req_ready = grant[0];
  assign ic_req_ready = grant[1];
  assign io_req_ready = grant[2];
  assign accept       = |grant;
  assign evict_load   = grant[0] & dc_evict;

  // cmd_pend mirrors the registered command valid in the mux
  assign cmd_acc   = cmd_pend & mem_cmd_ready;
  assign last_beat = flags.cnt_eq[BURST_LEN-1];
  assign miss_ack  = flags.curr_eq[DC_MISS_ACK] | flags.curr_eq[IC_MISS_ACK];
  assign cnt_en    = (flags.curr_eq[DC_MEM_WR] & cmd_acc) | (miss_ack & mem_rd_valid);

  assign beat_capture = mem_rd_valid & (miss_ack | (flags.curr_eq[IO_ACK_WAIT] & io_sent));

  // a new command only once the previous one has been taken
  assign cmd_issue = ~cmd_pend & (flags.curr_eq[DC_MEM_WR] | flags.curr_eq[DC_MEM_RD] |
                                  flags.curr_eq[IC_MEM_RD] |
                                  (flags.curr_eq[IO_ACK_WAIT] & ~io_sent));

  always_comb begin
    cmd_sel.latch = accept;
    if (flags.curr_eq[DC_MEM_WR]) begin
      cmd_sel.kind = CMD_EVICT_WR;
    end else if (flags.curr_eq[DC_MEM_RD]) begin
      cmd_sel.kind = CMD_DC_RD;
    end else if (flags.curr_eq[IC_MEM_RD]) begin
      cmd_sel.kind = CMD_IC_RD;
    end else begin
      cmd_sel.kind = CMD_IO;
    end
  end

  always_comb begin
    next_st = curr_st;
    if (flags.curr_eq[IO_SEL]) begin
      if (grant[0]) begin
        next_st = dc_evict ? DC_MEM_WR : DC_MEM_RD;
      end else if (grant[1]) begin
        next_st = IC_MEM_RD;
      end else if (grant[2]) begin
        next_st = IO_ACK_WAIT;
      end
    end
    if (flags.curr_eq[DC_MEM_WR] && cmd_acc && last_beat) begin
      next_st = DC_CLEAR_EVICT;
    end
    if (flags.curr_eq[DC_CLEAR_EVICT]) begin
      next_st = DC_MEM_RD;
    end
    if (flags.curr_eq[DC_MEM_RD] && cmd_acc) begin
      next_st = DC_MISS_ACK;
    end
    if (flags.curr_eq[IC_MEM_RD] && cmd_acc) begin
      next_st = IC_MISS_ACK;
    end
    if (miss_ack && mem_rd_valid && last_beat) begin
      next_st = IO_SEL;
    end
    // write ends on command accept, read on its single data beat
    if (flags.curr_eq[IO_ACK_WAIT] && ((cmd_acc && io_wr_q) || (io_sent && mem_rd_valid))) begin
      next_st = IO_SEL;
    end
  end

  // ready goes high the cycle after a request is seen, for exactly one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      grant <= '0;
    end else if (flags.curr_ne[IO_SEL] || accept) begin
      grant <= '0;
    end else begin
      grant[0] <= dc_req_valid;
      grant[1] <= ic_req_valid & ~dc_req_valid;
      grant[2] <= io_req_valid & ~dc_req_valid & ~ic_req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      curr_st       <= IO_SEL;
      count         <= '0;
      cmd_pend      <= 1'b0;
      io_sent       <= 1'b0;
      io_wr_q       <= 1'b0;
      dc_fill_valid <= 1'b0;
      ic_fill_valid <= 1'b0;
      io_rsp_valid  <= 1'b0;
    end else begin
      curr_st <= next_st;
      if (cnt_en) begin
        count <= count + 1'b1;
      end
      if (cmd_issue) begin
        cmd_pend <= 1'b1;
      end else if (mem_cmd_ready) begin
        cmd_pend <= 1'b0;
      end
      if (grant[2]) begin
        io_wr_q <= io_write;
      end
      io_sent <= flags.next_eq[IO_ACK_WAIT] & (io_sent | cmd_acc);
      // done pulses land in the first IO_SEL cycle
      dc_fill_valid <= flags.curr_eq[DC_MISS_ACK] & flags.next_eq[IO_SEL];
      ic_fill_valid <= flags.curr_eq[IC_MISS_ACK] & flags.next_eq[IO_SEL];
      io_rsp_valid  <= flags.curr_eq[IO_ACK_WAIT] & flags.next_eq[IO_SEL];
    end
  end

endmodule

// File: verilog/line_buffer.sv
// one-line data buffer between the memory read port and the caches
// holds the victim line during eviction, then gathers the eight fill beats

module line_buffer (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             evict_load,
  input  mem_bus_pkg::line_t               evict_line,
  input  logic                             beat_capture,
  input  logic [mem_bus_pkg::DATA_W-1:0]   rd_data,
  input  logic [mem_ctrl_pkg::CNT_W-1:0]   count,
  output logic [mem_bus_pkg::DATA_W-1:0]   evict_beat,
  output mem_bus_pkg::line_t               fill_line
);

  import mem_bus_pkg::*;

  line_t line_q;

  // victim load and fill capture never overlap, the victim is written out first
  always_ff @(posedge clk) begin
    if (rst) begin
      line_q <= '0;
    end else if (evict_load) begin
      line_q <= evict_line;
    end else if (beat_capture) begin
      // beat n lands in word n, so the line fills in order
      line_q[count] <= rd_data;
    end
  end

  // current write beat follows the counter as each write is accepted
  assign evict_beat = line_q[count];

  // an I/O read returns through word 0 of the same storage
  assign fill_line = line_q;

endmodule

// File: verilog/mem_cmd_mux.sv
// memory command register and request field latch
// builds evict writes, line bursts and single I/O accesses, holds them until ready

module mem_cmd_mux (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             cmd_issue,
  input  mem_ctrl_pkg::cmd_sel_t           cmd_sel,
  input  mem_bus_pkg::dc_req_t             dc_req,
  input  mem_bus_pkg::line_addr_t          ic_line,
  input  mem_bus_pkg::io_req_t             io_req,
  input  logic [mem_bus_pkg::DATA_W-1:0]   evict_beat,
  input  logic [mem_ctrl_pkg::CNT_W-1:0]   count,
  output logic                             mem_cmd_valid,
  output mem_bus_pkg::mem_cmd_t            mem_cmd,
  input  logic                             mem_cmd_ready
);

  import mem_ctrl_pkg::*;
  import mem_bus_pkg::*;

  line_addr_t fill_addr_q;
  line_addr_t evict_addr_q;
  line_addr_t ic_line_q;
  io_req_t    io_q;
  mem_cmd_t   cmd_d;

  // sources may change right after the accept cycle
  always_ff @(posedge clk) begin
    if (cmd_sel.latch) begin
      fill_addr_q  <= dc_req.fill_addr;
      evict_addr_q <= dc_req.evict_addr;
      ic_line_q    <= ic_line;
      io_q         <= io_req;
    end
  end

  always_comb begin
    cmd_d = '0;
    case (cmd_sel.kind)
      CMD_EVICT_WR: begin
        cmd_d.write        = 1'b1;
        cmd_d.addr.ln.line = evict_addr_q;
        cmd_d.addr.ln.beat = count;
        cmd_d.wdata        = evict_beat;
      end
      CMD_DC_RD: begin
        cmd_d.burst        = 1'b1;
        cmd_d.addr.ln.line = fill_addr_q;
      end
      CMD_IC_RD: begin
        cmd_d.burst        = 1'b1;
        cmd_d.addr.ln.line = ic_line_q;
      end
      default: begin
        cmd_d.write     = io_q.write;
        cmd_d.addr.word = io_q.addr;
        cmd_d.wdata     = io_q.wdata;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_cmd_valid <= 1'b0;
    end else if (cmd_issue) begin
      mem_cmd_valid <= 1'b1;
    end else if (mem_cmd_ready) begin
      mem_cmd_valid <= 1'b0;
    end
  end

  // payload keeps its last value after acceptance, the top reads the fill address from it
  always_ff @(posedge clk) begin
    if (cmd_issue) begin
      mem_cmd <= cmd_d;
    end
  end

endmodule

// File: verilog/mem_subsys_top.sv
// memory-side controller top: dc, ic and io requesters onto one memory port
// the decoder sits inside the FSM, datapath is the line buffer and command mux

module mem_subsys_top (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             dc_req_valid,
  output logic                             dc_req_ready,
  input  mem_bus_pkg::dc_req_t             dc_req,
  input  logic                             ic_req_valid,
  output logic                             ic_req_ready,
  input  mem_bus_pkg::line_addr_t          ic_req,
  input  logic                             io_req_valid,
  output logic                             io_req_ready,
  input  mem_bus_pkg::io_req_t             io_req,
  output logic                             dc_fill_valid,
  output mem_bus_pkg::fill_t               dc_fill,
  output logic                             ic_fill_valid,
  output mem_bus_pkg::fill_t               ic_fill,
  output logic                             io_rsp_valid,
  output logic [mem_bus_pkg::DATA_W-1:0]   io_rsp,
  output logic                             mem_cmd_valid,
  input  logic                             mem_cmd_ready,
  output mem_bus_pkg::mem_cmd_t            mem_cmd,
  input  logic                             mem_rd_valid,
  input  logic [mem_bus_pkg::DATA_W-1:0]   mem_rd
);

  import mem_ctrl_pkg::*;
  import mem_bus_pkg::*;

  logic              cmd_issue;
  cmd_sel_t          cmd_sel;
  logic              beat_capture;
  logic              evict_load;
  logic [CNT_W-1:0]  count;
  logic [DATA_W-1:0] evict_beat;
  line_t             fill_line;

  mem_ctrl_fsm i_fsm (
    .clk           (clk),
    .rst           (rst),
    .dc_req_valid  (dc_req_valid),
    .ic_req_valid  (ic_req_valid),
    .io_req_valid  (io_req_valid),
    .dc_evict      (dc_req.evict),
    .io_write      (io_req.write),
    .dc_req_ready  (dc_req_ready),
    .ic_req_ready  (ic_req_ready),
    .io_req_ready  (io_req_ready),
    .mem_cmd_ready (mem_cmd_ready),
    .mem_rd_valid  (mem_rd_valid),
    .cmd_issue     (cmd_issue),
    .cmd_sel       (cmd_sel),
    .beat_capture  (beat_capture),
    .evict_load    (evict_load),
    .dc_fill_valid (dc_fill_valid),
    .ic_fill_valid (ic_fill_valid),
    .io_rsp_valid  (io_rsp_valid),
    .count         (count)
  );

  line_buffer i_line_buf (
    .clk          (clk),
    .rst          (rst),
    .evict_load   (evict_load),
    .evict_line   (dc_req.evict_line),
    .beat_capture (beat_capture),
    .rd_data      (mem_rd),
    .count        (count),
    .evict_beat   (evict_beat),
    .fill_line    (fill_line)
  );

  mem_cmd_mux i_cmd_mux (
    .clk           (clk),
    .rst           (rst),
    .cmd_issue     (cmd_issue),
    .cmd_sel       (cmd_sel),
    .dc_req        (dc_req),
    .ic_line       (ic_req),
    .io_req        (io_req),
    .evict_beat    (evict_beat),
    .count         (count),
    .mem_cmd_valid (mem_cmd_valid),
    .mem_cmd       (mem_cmd),
    .mem_cmd_ready (mem_cmd_ready)
  );

  // the burst read stays in the command register until the fill is done
  assign dc_fill = '{line_addr: mem_cmd.addr.ln.line, data: fill_line};
  assign ic_fill = '{line_addr: mem_cmd.addr.ln.line, data: fill_line};
  assign io_rsp  = fill_line[0];

endmodule

// File: dv/tb_clk_gen.sv
// free-running testbench clock, 100 ns period
// starts low, first rising edge at 50 ns

module tb_clk_gen (
  output logic clk
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam time HALF_PERIOD = 50ns;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

endmodule

// File: dv/mem_subsys_asserts.sv
// protocol checks on the memory controller FSM
// bound into every mem_ctrl_fsm instance from the testbench side

module mem_ctrl_asserts (
  input logic                           clk,
  input logic                           rst,
  input mem_ctrl_pkg::mem_st_t          curr_st,
  input logic [mem_ctrl_pkg::CNT_W-1:0] count,
  input logic                           dc_req_ready,
  input logic                           ic_req_ready,
  input logic                           io_req_ready,
  input logic                           cmd_pend,
  input logic                           cmd_issue,
  input logic                           mem_cmd_ready,
  input logic                           dc_fill_valid,
  input logic                           ic_fill_valid,
  input logic                           io_rsp_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  import mem_ctrl_pkg::*;

  logic any_ready;
  logic any_done;
  logic in_service;

  assign any_ready = dc_req_ready | ic_req_ready | io_req_ready;
  assign any_done  = dc_fill_valid | ic_fill_valid | io_rsp_valid;

  // high from an accept until the matching done pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      in_service <= 1'b0;
    end else if (any_ready) begin
      in_service <= 1'b1;
    end else if (any_done) begin
      in_service <= 1'b0;
    end
  end

  a_accept_idle: assert property (@(posedge clk) disable iff (rst)
    any_ready |-> (curr_st == IO_SEL))
    else $error("request accepted outside arbitration");

  a_accept_pulse: assert property (@(posedge clk) disable iff (rst)
    any_ready |=> !any_ready)
    else $error("request ready held longer than one cycle");

  a_cmd_held: assert property (@(posedge clk) disable iff (rst)
    (cmd_pend && !mem_cmd_ready) |=> (cmd_pend && $stable(count) && $stable(curr_st)))
    else $error("memory command withdrawn or moved on before ready");

  a_issue_in_service: assert property (@(posedge clk) disable iff (rst)
    cmd_issue |-> in_service)
    else $error("memory command issued with no request in service");

  a_done_after_accept: assert property (@(posedge clk) disable iff (rst)
    any_done |-> in_service)
    else $error("response valid without an accepted request");

  a_reset_quiet: assert property (@(posedge clk)
    rst |=> !(any_ready || any_done || cmd_pend))
    else $error("handshake outputs active right after reset");

endmodule

bind mem_ctrl_fsm mem_ctrl_asserts i_fsm_asserts (
  .clk           (clk),
  .rst           (rst),
  .curr_st       (curr_st),
  .count         (count),
  .dc_req_ready  (dc_req_ready),
  .ic_req_ready  (ic_req_ready),
  .io_req_ready  (io_req_ready),
  .cmd_pend      (cmd_pend),
  .cmd_issue     (cmd_issue),
  .mem_cmd_ready (mem_cmd_ready),
  .dc_fill_valid (dc_fill_valid),
  .ic_fill_valid (ic_fill_valid),
  .io_rsp_valid  (io_rsp_valid)
);

// File: dv/mem_subsys_tb.sv
// testbench for the memory subsystem with random dc, ic and io traffic on a behavioral memory
// expected fills, read data and command words come from a reference copy of memory

module mem_subsys_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import mem_ctrl_pkg::*;
  import mem_bus_pkg::*;

  localparam int MEM_WORDS   = 1 << ADDR_W;
  localparam int SEED        = 38003;
  localparam int NUM_IC      = 6;
  localparam int NUM_DC      = 8;
  localparam int NUM_IO      = 6;
  localparam int NUM_ARB     = 3;
  localparam int NUM_REQ     = NUM_IC + NUM_DC + 2 * NUM_IO + 3 * NUM_ARB;
  // 40 cycles covers an evicting miss with ready and read gaps
  localparam int TIMEOUT_CYC = NUM_REQ * 40 + 200;

  logic              clk;
  logic              rst;
  logic              dc_req_valid;
  logic              dc_req_ready;
  dc_req_t           dc_req;
  logic              ic_req_valid;
  logic              ic_req_ready;
  line_addr_t        ic_req;
  logic              io_req_valid;
  logic              io_req_ready;
  io_req_t           io_req;
  logic              dc_fill_valid;
  fill_t             dc_fill;
  logic              ic_fill_valid;
  fill_t             ic_fill;
  logic              io_rsp_valid;
  logic [DATA_W-1:0] io_rsp;
  logic              mem_cmd_valid;
  logic              mem_cmd_ready;
  mem_cmd_t          mem_cmd;
  logic              mem_rd_valid;
  logic [DATA_W-1:0] mem_rd;

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [DATA_W-1:0] ref_mem [MEM_WORDS];
  mem_cmd_t          cmd_log[$];
  int                cyc;
  int                err_cnt;
  int                tests_run;
  int                tests_failed;
  int                test_err_start;
  string             test_name;

  tb_clk_gen i_clk_gen (.clk(clk));

  mem_subsys_top i_dut (
    .clk           (clk),
    .rst           (rst),
    .dc_req_valid  (dc_req_valid),
    .dc_req_ready  (dc_req_ready),
    .dc_req        (dc_req),
    .ic_req_valid  (ic_req_valid),
    .ic_req_ready  (ic_req_ready),
    .ic_req        (ic_req),
    .io_req_valid  (io_req_valid),
    .io_req_ready  (io_req_ready),
    .io_req        (io_req),
    .dc_fill_valid (dc_fill_valid),
    .dc_fill       (dc_fill),
    .ic_fill_valid (ic_fill_valid),
    .ic_fill       (ic_fill),
    .io_rsp_valid  (io_rsp_valid),
    .io_rsp        (io_rsp),
    .mem_cmd_valid (mem_cmd_valid),
    .mem_cmd_ready (mem_cmd_ready),
    .mem_cmd       (mem_cmd),
    .mem_rd_valid  (mem_rd_valid),
    .mem_rd        (mem_rd)
  );

  // initial memory contents where every word differs from its neighbours
  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
    return {~a, a ^ 16'h5a3c};
  endfunction

  function automatic logic [6:0] ctrl_outputs();
    return {dc_req_ready, ic_req_ready, io_req_ready, mem_cmd_valid,
            dc_fill_valid, ic_fill_valid, io_rsp_valid};
  endfunction

  function automatic mem_cmd_t burst_cmd(input line_addr_t line);
    mem_cmd_t c;
    c = '0;
    c.burst     = 1'b1;
    c.addr.word = {line, BEAT_W'(0)};
    return c;
  endfunction

  function automatic fill_t expect_fill(input line_addr_t line);
    fill_t f;
    f.line_addr = line;
    for (int b = 0; b < BURST_LEN; b++) begin
      f.data[b] = ref_mem[{line, BEAT_W'(b)}];
    end
    return f;
  endfunction

  task automatic check_ctrl(input string name, input logic [6:0] exp, input logic [6:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("[ERROR] %s: control outputs expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_fill(input string name, input fill_t exp, input fill_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("[ERROR] %s: fill expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_io(input string name, input logic [DATA_W-1:0] exp,
                          input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("[ERROR] %s: read data expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_cmd(input string name, input mem_cmd_t exp, input mem_cmd_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("[ERROR] %s: cmd (wr/burst/addr/data) expected %b/%b/%h/%h actual %b/%b/%h/%h",
               name, exp.write, exp.burst, exp.addr.word, exp.wdata,
               act.write, act.burst, act.addr.word, act.wdata);
    end
  endtask

  // matches the commands the memory saw against the expected list in order
  task automatic check_cmd_list(input string name, input mem_cmd_t exp_q[$]);
    int n;
    if (cmd_log.size() != exp_q.size()) begin
      err_cnt++;
      $display("[ERROR] %s: command count expected %0d actual %0d",
               name, exp_q.size(), cmd_log.size());
    end
    n = (cmd_log.size() < exp_q.size()) ? cmd_log.size() : exp_q.size();
    for (int i = 0; i < n; i++) begin
      check_cmd(name, exp_q[i], cmd_log[i]);
    end
    cmd_log.delete();
  endtask

  task automatic begin_test(input string name);
    test_name      = name;
    test_err_start = err_cnt;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_cnt == test_err_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, err_cnt - test_err_start);
    end
  endtask

  task automatic run_ic(input string name, input line_addr_t line, output int acc_cyc,
                        output int done_cyc);
    mem_cmd_t exp_q[$];
    fill_t    exp_fill;
    @(posedge clk);
    #1;
    ic_req       = line;
    ic_req_valid = 1'b1;
    @(negedge clk);
    while (!ic_req_ready) @(negedge clk);
    acc_cyc = cyc;
    exp_q.push_back(burst_cmd(line));
    exp_fill = expect_fill(line);
    @(posedge clk);
    #1;
    ic_req_valid = 1'b0;
    @(negedge clk);
    while (!ic_fill_valid) @(negedge clk);
    done_cyc = cyc;
    check_fill(name, exp_fill, ic_fill);
    check_cmd_list(name, exp_q);
  endtask

  task automatic run_dc(input string name, input line_addr_t fill_line, input logic evict,
                        input line_addr_t victim, output int acc_cyc, output int done_cyc);
    dc_req_t  req;
    mem_cmd_t exp_q[$];
    mem_cmd_t c;
    fill_t    exp_fill;
    req.fill_addr  = fill_line;
    req.evict      = evict;
    req.evict_addr = victim;
    for (int w = 0; w < BURST_LEN; w++) begin
      req.evict_line[w] = $urandom;
    end
    @(posedge clk);
    #1;
    dc_req       = req;
    dc_req_valid = 1'b1;
    @(negedge clk);
    while (!dc_req_ready) @(negedge clk);
    acc_cyc = cyc;
    // writeback lands in memory before the fill is read
    if (evict) begin
      for (int b = 0; b < BURST_LEN; b++) begin
        c = '0;
        c.write     = 1'b1;
        c.addr.word = {victim, BEAT_W'(b)};
        c.wdata     = req.evict_line[b];
        exp_q.push_back(c);
        ref_mem[c.addr.word] = c.wdata;
      end
    end
    exp_q.push_back(burst_cmd(fill_line));
    exp_fill = expect_fill(fill_line);
    @(posedge clk);
    #1;
    dc_req_valid = 1'b0;
    @(negedge clk);
    while (!dc_fill_valid) @(negedge clk);
    done_cyc = cyc;
    check_fill(name, exp_fill, dc_fill);
    check_cmd_list(name, exp_q);
  endtask

  task automatic run_io(input string name, input logic write, input logic [ADDR_W-1:0] addr,
                        input logic [DATA_W-1:0] wdata, output int acc_cyc, output int done_cyc);
    mem_cmd_t          exp_q[$];
    mem_cmd_t          c;
    logic [DATA_W-1:0] exp_rd;
    @(posedge clk);
    #1;
    io_req.write = write;
    io_req.addr  = addr;
    io_req.wdata = write ? wdata : '0;
    io_req_valid = 1'b1;
    @(negedge clk);
    while (!io_req_ready) @(negedge clk);
    acc_cyc = cyc;
    c = '0;
    c.write     = write;
    c.addr.word = addr;
    c.wdata     = io_req.wdata;
    exp_q.push_back(c);
    exp_rd = ref_mem[addr];
    if (write) begin
      ref_mem[addr] = wdata;
    end
    @(posedge clk);
    #1;
    io_req_valid = 1'b0;
    @(negedge clk);
    while (!io_rsp_valid) @(negedge clk);
    done_cyc = cyc;
    if (!write) begin
      check_io(name, exp_rd, io_rsp);
    end
    check_cmd_list(name, exp_q);
  endtask

  // small line pool so misses, fills and io accesses hit each other
  function automatic line_addr_t rand_line();
    return line_addr_t'($urandom_range(63));
  endfunction

  // behavioral memory with random command ready and random gaps between read beats
  initial begin : mem_model
    mem_cmd_t          held_cmd;
    logic              held;
    logic [DATA_W-1:0] rd_q[$];
    mem_cmd_ready = 1'b0;
    mem_rd_valid  = 1'b0;
    mem_rd        = '0;
    held          = 1'b0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a] = fill_word(ADDR_W'(a));
    end
    forever begin
      @(negedge clk);
      if (held) begin
        if (!mem_cmd_valid) begin
          err_cnt++;
          $display("[ERROR] %s: mem_cmd_valid dropped while waiting for ready", test_name);
        end
        check_cmd(test_name, held_cmd, mem_cmd);
      end
      held     = mem_cmd_valid && !mem_cmd_ready && !rst;
      held_cmd = mem_cmd;
      if (mem_cmd_valid && mem_cmd_ready && !rst) begin
        cmd_log.push_back(mem_cmd);
        if (mem_cmd.write) begin
          mem[mem_cmd.addr.word] = mem_cmd.wdata;
        end else if (mem_cmd.burst) begin
          for (int b = 0; b < BURST_LEN; b++) begin
            rd_q.push_back(mem[{mem_cmd.addr.ln.line, BEAT_W'(b)}]);
          end
        end else begin
          rd_q.push_back(mem[mem_cmd.addr.word]);
        end
      end
      @(posedge clk);
      #1;
      mem_cmd_ready = ($urandom_range(3) != 0);
      if (rd_q.size() > 0 && $urandom_range(3) != 0) begin
        mem_rd_valid = 1'b1;
        mem_rd       = rd_q.pop_front();
      end else begin
        mem_rd_valid = 1'b0;
        mem_rd       = $urandom;
      end
    end
  end

  initial begin : watchdog
    cyc = 0;
    while (cyc <= TIMEOUT_CYC) begin
      @(posedge clk);
      cyc++;
    end
    $display("run stopped after %0d cycles before all tests finished", TIMEOUT_CYC);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin : main
    int                acc_dc;
    int                acc_ic;
    int                acc_io;
    int                done_dc;
    int                done_ic;
    int                done_io;
    line_addr_t        fl;
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] d;
    string             name;
    void'($urandom(SEED));
    err_cnt      = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst          = 1'b1;
    dc_req_valid = 1'b0;
    dc_req       = '0;
    ic_req_valid = 1'b0;
    ic_req       = '0;
    io_req_valid = 1'b0;
    io_req       = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = fill_word(ADDR_W'(i));
    end

    // outputs stay quiet during reset and just after it
    begin_test("reset_state");
    repeat (9) begin
      @(posedge clk);
      @(negedge clk);
      check_ctrl("reset_state", '0, ctrl_outputs());
    end
    @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_ctrl("reset_state", '0, ctrl_outputs());
    end
    end_test("reset_state");

    for (int i = 0; i < NUM_IC; i++) begin
      name = $sformatf("ic_fill_%0d", i);
      begin_test(name);
      run_ic(name, rand_line(), acc_ic, done_ic);
      end_test(name);
    end

    for (int i = 0; i < NUM_DC; i++) begin
      name = $sformatf("dc_miss_%0d", i);
      fl   = rand_line();
      begin_test(name);
      // even tests refill the line that was just written back
      run_dc(name, fl, (i % 4) != 3, (i % 2 == 0) ? fl : rand_line(), acc_dc, done_dc);
      end_test(name);
    end

    for (int i = 0; i < NUM_IO; i++) begin
      name = $sformatf("io_wr_rd_%0d", i);
      a    = {rand_line(), BEAT_W'($urandom_range(BURST_LEN - 1))};
      d    = $urandom;
      begin_test(name);
      run_io(name, 1'b1, a, d, acc_io, done_io);
      run_io(name, 1'b0, a, '0, acc_io, done_io);
      end_test(name);
    end

    for (int i = 0; i < NUM_ARB; i++) begin
      name = $sformatf("arbitration_%0d", i);
      a    = {rand_line(), BEAT_W'($urandom_range(BURST_LEN - 1))};
      d    = $urandom;
      begin_test(name);
      fork
        run_dc({name, "_dc"}, rand_line(), 1'($urandom_range(1)), rand_line(), acc_dc, done_dc);
        run_ic({name, "_ic"}, rand_line(), acc_ic, done_ic);
        run_io({name, "_io"}, 1'($urandom_range(1)), a, d, acc_io, done_io);
      join
      if (!(acc_dc < acc_ic && acc_ic < acc_io)) begin
        err_cnt++;
        $display("[ERROR] %s: requests were not accepted in the order dc, ic, io", name);
      end
      if (acc_ic <= done_dc || acc_io <= done_ic) begin
        err_cnt++;
        $display("[ERROR] %s: a request was accepted before the previous one finished", name);
      end
      end_test(name);
    end

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: mem_subsys.f
common/mem_ctrl_pkg.sv
common/mem_bus_pkg.sv
mem_ctrl/st_eq_checker.sv
mem_ctrl/mem_ctrl_fsm.sv
verilog/line_buffer.sv
verilog/mem_cmd_mux.sv
verilog/mem_subsys_top.sv
dv/tb_clk_gen.sv
dv/mem_subsys_asserts.sv
dv/mem_subsys_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := mem_subsys_tb
FILELIST  := mem_subsys.f
VFLAGS    := --timing --assert --timescale 1ns/1ps
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
